/* logic/decodePkg.sv */
`default_nettype none

package decodePkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    localparam int InstrWidth    = 16;
    localparam int OpWidth       = 5;
    localparam int RegFieldWidth = 3;   // rx/ry/rz inside the word
    localparam int RegIdxWidth   = 4;
    localparam int AluOpWidth    = 4;
    localparam int SelWidth      = 2;
    localparam int ImmKindWidth  = 3;

    // Special register indices
    localparam logic [RegIdxWidth-1:0] RegSp   = 4'd8;
    localparam logic [RegIdxWidth-1:0] RegT    = 4'd9;
    localparam logic [RegIdxWidth-1:0] RegNone = 4'd15;  // Reads zero, writes dropped

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    localparam logic [OpWidth-1:0] OpNop      = 5'b00001;
    localparam logic [OpWidth-1:0] OpB        = 5'b00010;
    localparam logic [OpWidth-1:0] OpBeqz     = 5'b00100;
    localparam logic [OpWidth-1:0] OpBnez     = 5'b00101;
    localparam logic [OpWidth-1:0] OpShift    = 5'b00110;  // SLL, SRA
    localparam logic [OpWidth-1:0] OpAddiu3   = 5'b01000;
    localparam logic [OpWidth-1:0] OpAddiu    = 5'b01001;
    localparam logic [OpWidth-1:0] OpSpGroup  = 5'b01100;  // ADDSP, BTEQZ, MTSP
    localparam logic [OpWidth-1:0] OpLi       = 5'b01101;
    localparam logic [OpWidth-1:0] OpMove     = 5'b01111;
    localparam logic [OpWidth-1:0] OpLwSp     = 5'b10010;
    localparam logic [OpWidth-1:0] OpLw       = 5'b10011;
    localparam logic [OpWidth-1:0] OpSwSp     = 5'b11010;
    localparam logic [OpWidth-1:0] OpSw       = 5'b11011;
    localparam logic [OpWidth-1:0] OpAddSub   = 5'b11100;  // ADDU, SUBU
    localparam logic [OpWidth-1:0] OpAluGroup = 5'b11101;  // JR, CMP, AND, OR

    //////////////////////////////////////////////////////////////////////
    // Control codes
    localparam logic [AluOpWidth-1:0] AluAdd = 4'b0000;
    localparam logic [AluOpWidth-1:0] AluSub = 4'b0001;
    localparam logic [AluOpWidth-1:0] AluAnd = 4'b0010;
    localparam logic [AluOpWidth-1:0] AluOr  = 4'b0011;
    localparam logic [AluOpWidth-1:0] AluSll = 4'b0110;
    localparam logic [AluOpWidth-1:0] AluSra = 4'b1000;
    localparam logic [AluOpWidth-1:0] AluCmp = 4'b1010;

    localparam logic [SelWidth-1:0] SrcBReg  = 2'b00;
    localparam logic [SelWidth-1:0] SrcBImm  = 2'b01;
    localparam logic [SelWidth-1:0] SrcBNone = 2'b10;

    localparam logic [SelWidth-1:0] MemRead  = 2'b01;
    localparam logic [SelWidth-1:0] MemWrite = 2'b10;
    localparam logic [SelWidth-1:0] MemNone  = 2'b11;

    localparam logic [SelWidth-1:0] CondAlways = 2'b00;
    localparam logic [SelWidth-1:0] CondReg    = 2'b01;  // Target from rx
    localparam logic [SelWidth-1:0] CondEqz    = 2'b10;
    localparam logic [SelWidth-1:0] CondNez    = 2'b11;

    // Immediate kinds
    localparam logic [ImmKindWidth-1:0] ImmZero   = 3'd0;
    localparam logic [ImmKindWidth-1:0] ImmSext11 = 3'd1;
    localparam logic [ImmKindWidth-1:0] ImmSext8  = 3'd2;
    localparam logic [ImmKindWidth-1:0] ImmZext8  = 3'd3;
    localparam logic [ImmKindWidth-1:0] ImmSext5  = 3'd4;
    localparam logic [ImmKindWidth-1:0] ImmSext4  = 3'd5;
    localparam logic [ImmKindWidth-1:0] ImmShamt  = 3'd6;  // Zero field means 8

    // Instruction word, three layouts of the same 16 bits
    typedef union packed {
        struct packed {
            logic [OpWidth-1:0]       op;
            logic [RegFieldWidth-1:0] rx;
            logic [7:0]               imm8;
        } rri;
        struct packed {
            logic [OpWidth-1:0]       op;
            logic [RegFieldWidth-1:0] rx;
            logic [RegFieldWidth-1:0] ry;
            logic [RegFieldWidth-1:0] rz;
            logic [1:0]               funct2;
        } rrr;
        struct packed {
            logic [OpWidth-1:0]       op;
            logic [RegFieldWidth-1:0] rx;
            logic [RegFieldWidth-1:0] ry;
            logic [4:0]               funct5;
        } rr;
    } instr_u;

endpackage

`default_nettype wire

/* logic/instrDecoder.sv */
`default_nettype none

module instrDecoder (
    input  decodePkg::instr_u                    instr,
    output logic [decodePkg::RegIdxWidth-1:0]  readReg1,
    output logic [decodePkg::RegIdxWidth-1:0]  readReg2,
    output logic [decodePkg::RegIdxWidth-1:0]  writeReg,
    output logic [decodePkg::AluOpWidth-1:0]   aluOp,
    output logic [decodePkg::SelWidth-1:0]     srcBSel,
    output logic [decodePkg::SelWidth-1:0]     memOp,
    output logic                               branch,
    output logic [decodePkg::SelWidth-1:0]     branchCond,
    output logic                               wbFromMem,
    output logic [decodePkg::ImmKindWidth-1:0] immKind
);
    import decodePkg::*;

    logic [RegIdxWidth-1:0] rxIdx;
    logic [RegIdxWidth-1:0] ryIdx;
    logic [RegIdxWidth-1:0] rzIdx;

    // Three-bit fields widened to full register indices
    assign rxIdx = {{(RegIdxWidth-RegFieldWidth){1'b0}}, instr.rrr.rx};
    assign ryIdx = {{(RegIdxWidth-RegFieldWidth){1'b0}}, instr.rrr.ry};
    assign rzIdx = {{(RegIdxWidth-RegFieldWidth){1'b0}}, instr.rrr.rz};

    always_comb begin
        // Default bundle, a bubble
        readReg1   = RegNone;
        readReg2   = RegNone;
        writeReg   = RegNone;
        aluOp      = AluAdd;
        srcBSel    = SrcBNone;
        memOp      = MemNone;
        branch     = 1'b0;
        branchCond = CondNez;
        wbFromMem  = 1'b0;
        immKind    = ImmZero;

        case (instr.rri.op)
            OpNop: ;
            OpB: begin
                branch     = 1'b1;
                branchCond = CondAlways;
                immKind    = ImmSext11;
            end
            OpBeqz, OpBnez: begin
                readReg1   = rxIdx;
                aluOp      = AluSub;
                branch     = 1'b1;
                branchCond = (instr.rri.op == OpBeqz) ? CondEqz : CondNez;
                immKind    = ImmSext8;
            end
            OpShift: begin
                case (instr.rrr.funct2)
                    2'b00, 2'b11: begin
                        readReg1 = ryIdx;
                        aluOp    = (instr.rrr.funct2 == 2'b00) ? AluSll : AluSra;
                        srcBSel  = SrcBImm;
                        immKind  = ImmShamt;
                        writeReg = rxIdx;
                    end
                    default: ;
                endcase
            end
            OpAddiu3: begin
                readReg1 = rxIdx;
                srcBSel  = SrcBImm;
                immKind  = ImmSext4;
                writeReg = ryIdx;
            end
            OpAddiu: begin
                readReg1 = rxIdx;
                srcBSel  = SrcBImm;
                immKind  = ImmSext8;
                writeReg = rxIdx;
            end

            //////////////////////////////////////////////////////////////////
            // SP and T group, selected by the rx field
            OpSpGroup: begin
                case (instr.rri.rx)
                    3'b011: begin  // ADDSP
                        readReg1 = RegSp;
                        srcBSel  = SrcBImm;
                        immKind  = ImmSext8;
                        writeReg = RegSp;
                    end
                    3'b000: begin  // BTEQZ
                        readReg1   = RegT;
                        aluOp      = AluSub;
                        branch     = 1'b1;
                        branchCond = CondEqz;
                        immKind    = ImmSext8;
                    end
                    3'b100: begin  // MTSP
                        readReg1 = ryIdx;
                        writeReg = RegSp;
                    end
                    default: ;
                endcase
            end
            OpLi: begin
                srcBSel  = SrcBImm;
                immKind  = ImmZext8;
                writeReg = rxIdx;
            end
            OpMove: begin
                readReg1 = ryIdx;
                srcBSel  = SrcBReg;
                writeReg = rxIdx;
            end

            //////////////////////////////////////////////////////////////////
            // Loads and stores
            OpLwSp: begin
                readReg1  = RegSp;
                srcBSel   = SrcBImm;
                memOp     = MemRead;
                wbFromMem = 1'b1;
                immKind   = ImmSext8;
                writeReg  = rxIdx;
            end
            OpLw: begin
                readReg1  = rxIdx;
                srcBSel   = SrcBImm;
                memOp     = MemRead;
                wbFromMem = 1'b1;
                immKind   = ImmSext5;
                writeReg  = ryIdx;
            end
            OpSwSp: begin
                readReg1 = RegSp;
                readReg2 = rxIdx;  // Store data
                memOp    = MemWrite;
                immKind  = ImmSext8;
            end
            OpSw: begin
                readReg1 = rxIdx;
                readReg2 = ryIdx;
                srcBSel  = SrcBImm;
                memOp    = MemWrite;
                immKind  = ImmSext5;
            end

            //////////////////////////////////////////////////////////////////
            // Register-register arithmetic
            OpAddSub: begin
                case (instr.rrr.funct2)
                    2'b01, 2'b11: begin
                        readReg1 = rxIdx;
                        readReg2 = ryIdx;
                        srcBSel  = SrcBReg;
                        aluOp    = (instr.rrr.funct2 == 2'b01) ? AluAdd : AluSub;
                        writeReg = rzIdx;
                    end
                    default: ;
                endcase
            end
            OpAluGroup: begin
                case (instr.rr.funct5)
                    5'b00000: begin
                        if (instr.rr.ry == 3'b000) begin  // JR
                            readReg1   = rxIdx;
                            branch     = 1'b1;
                            branchCond = CondReg;
                        end
                    end
                    5'b01010: begin  // CMP writes T
                        readReg1 = rxIdx;
                        readReg2 = ryIdx;
                        srcBSel  = SrcBReg;
                        aluOp    = AluCmp;
                        writeReg = RegT;
                    end
                    5'b01100, 5'b01101: begin
                        readReg1 = rxIdx;
                        readReg2 = ryIdx;
                        srcBSel  = SrcBReg;
                        aluOp    = (instr.rr.funct5 == 5'b01100) ? AluAnd : AluOr;
                        writeReg = rxIdx;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/immExtend.sv */
`default_nettype none

module immExtend #(
    parameter int DataWidth = 16
) (
    input  decodePkg::instr_u                    instr,
    input  logic [decodePkg::ImmKindWidth-1:0] immKind,
    output logic [DataWidth-1:0]               imm
);
    import decodePkg::*;

    logic [RegFieldWidth-1:0] shamt;

    assign shamt = instr.rrr.rz;

    always_comb begin
        case (immKind)
            ImmSext11: begin  // Branch offset spans rx and imm8
                imm = {{(DataWidth-11){instr.rri.rx[RegFieldWidth-1]}},
                       instr.rri.rx, instr.rri.imm8};
            end
            ImmSext8: begin
                imm = {{(DataWidth-8){instr.rri.imm8[7]}}, instr.rri.imm8};
            end
            ImmZext8: begin
                imm = DataWidth'(instr.rri.imm8);
            end
            ImmSext5: begin
                imm = {{(DataWidth-5){instr.rr.funct5[4]}}, instr.rr.funct5};
            end
            ImmSext4: begin
                imm = {{(DataWidth-4){instr[3]}}, instr[3:0]};
            end
            ImmShamt: begin
                // A zero shift field encodes a shift by 8
                imm = (shamt == '0) ? DataWidth'(8) : DataWidth'(shamt);
            end
            default: imm = '0;  // ImmZero and spare codes
        endcase
    end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none

module regFile #(
    parameter int DataWidth = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [decodePkg::RegIdxWidth-1:0] readReg1,
    input  logic [decodePkg::RegIdxWidth-1:0] readReg2,
    input  logic [decodePkg::RegIdxWidth-1:0] writeBackReg,
    input  logic [DataWidth-1:0]              writeBackData,
    output logic [DataWidth-1:0]              readData1,
    output logic [DataWidth-1:0]              readData2
);
    import decodePkg::*;

    localparam int NumRegs = 2 ** RegIdxWidth;

    logic [DataWidth-1:0] regs [NumRegs];

    //////////////////////////////////////////////////////////////////////
    // Write port
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeBackReg != RegNone) begin
            regs[writeBackReg] <= writeBackData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports
    function automatic logic [DataWidth-1:0] readPort(
        input logic [RegIdxWidth-1:0] idx
    );
        logic [DataWidth-1:0] data;
        if (idx == RegNone) begin
            data = '0;
        end else if (idx == writeBackReg) begin
            data = writeBackData;  // Same-cycle bypass
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_comb begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
    end

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`default_nettype none

module decodeStage #(
    parameter int DataWidth = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [decodePkg::InstrWidth-1:0]   instr,
    input  logic [decodePkg::RegIdxWidth-1:0]  writeBackReg,
    input  logic [DataWidth-1:0]               writeBackData,
    output logic [decodePkg::AluOpWidth-1:0]   aluOp,
    output logic [decodePkg::SelWidth-1:0]     srcBSel,
    output logic [decodePkg::SelWidth-1:0]     memOp,
    output logic                               branch,
    output logic [decodePkg::SelWidth-1:0]     branchCond,
    output logic                               wbFromMem,
    output logic [DataWidth-1:0]               imm,
    output logic [decodePkg::RegIdxWidth-1:0]  writeReg,
    output logic [decodePkg::RegIdxWidth-1:0]  readReg1,
    output logic [decodePkg::RegIdxWidth-1:0]  readReg2,
    output logic [DataWidth-1:0]               readData1,
    output logic [DataWidth-1:0]               readData2
);
    import decodePkg::*;

    logic [ImmKindWidth-1:0] immKind;

    instrDecoder decoder (
        .instr      (instr),
        .readReg1   (readReg1),
        .readReg2   (readReg2),
        .writeReg   (writeReg),
        .aluOp      (aluOp),
        .srcBSel    (srcBSel),
        .memOp      (memOp),
        .branch     (branch),
        .branchCond (branchCond),
        .wbFromMem  (wbFromMem),
        .immKind    (immKind)
    );

    immExtend #(.DataWidth(DataWidth)) extender (
        .instr   (instr),
        .immKind (immKind),
        .imm     (imm)
    );

    // Read indices come straight from the decoder
    regFile #(.DataWidth(DataWidth)) registers (
        .clk           (clk),
        .rst           (rst),
        .readReg1      (readReg1),
        .readReg2      (readReg2),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .readData1     (readData1),
        .readData2     (readData2)
    );

endmodule

`default_nettype wire

/* dv/decodeRef.svh */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected control bundle and immediate for one instruction word
function automatic void decodeRef(
    input  logic [15:0] ins,
    output logic [3:0]  r1,
    output logic [3:0]  r2,
    output logic [3:0]  w,
    output logic [3:0]  alu,
    output logic [1:0]  srcB,
    output logic [1:0]  mem,
    output logic        br,
    output logic [1:0]  cond,
    output logic        wbm,
    output logic [15:0] immVal
);
    logic [3:0] rx;
    logic [3:0] ry;
    logic [3:0] rz;
    logic [2:0] kind;
    rx = {1'b0, ins[10:8]};
    ry = {1'b0, ins[7:5]};
    rz = {1'b0, ins[4:2]};
    r1 = RegNone;
    r2 = RegNone;
    w = RegNone;
    alu = AluAdd;
    srcB = SrcBNone;
    mem = MemNone;
    br = 1'b0;
    cond = CondNez;
    wbm = 1'b0;
    kind = ImmZero;
    case (ins[15:11])
        5'b00010: begin
            br = 1'b1;
            cond = CondAlways;
            kind = ImmSext11;
        end
        5'b00100: begin
            r1 = rx;
            alu = AluSub;
            br = 1'b1;
            cond = CondEqz;
            kind = ImmSext8;
        end
        5'b00101: begin
            r1 = rx;
            alu = AluSub;
            br = 1'b1;
            cond = CondNez;
            kind = ImmSext8;
        end
        5'b00110: begin
            if (ins[1:0] == 2'b00 || ins[1:0] == 2'b11) begin
                r1 = ry;
                alu = (ins[1:0] == 2'b00) ? AluSll : AluSra;
                srcB = SrcBImm;
                kind = ImmShamt;
                w = rx;
            end
        end
        5'b01000: begin
            r1 = rx;
            srcB = SrcBImm;
            kind = ImmSext4;
            w = ry;
        end
        5'b01001: begin
            r1 = rx;
            srcB = SrcBImm;
            kind = ImmSext8;
            w = rx;
        end
        5'b01100: begin
            if (ins[10:8] == 3'b011) begin
                r1 = RegSp;
                srcB = SrcBImm;
                kind = ImmSext8;
                w = RegSp;
            end else if (ins[10:8] == 3'b000) begin
                r1 = RegT;
                alu = AluSub;
                br = 1'b1;
                cond = CondEqz;
                kind = ImmSext8;
            end else if (ins[10:8] == 3'b100) begin
                r1 = ry;
                w = RegSp;
            end
        end
        5'b01101: begin
            srcB = SrcBImm;
            kind = ImmZext8;
            w = rx;
        end
        5'b01111: begin
            r1 = ry;
            srcB = SrcBReg;
            w = rx;
        end
        5'b10010: begin
            r1 = RegSp;
            srcB = SrcBImm;
            mem = MemRead;
            wbm = 1'b1;
            kind = ImmSext8;
            w = rx;
        end
        5'b10011: begin
            r1 = rx;
            srcB = SrcBImm;
            mem = MemRead;
            wbm = 1'b1;
            kind = ImmSext5;
            w = ry;
        end
        5'b11010: begin
            r1 = RegSp;
            r2 = rx;
            mem = MemWrite;
            kind = ImmSext8;
        end
        5'b11011: begin
            r1 = rx;
            r2 = ry;
            srcB = SrcBImm;
            mem = MemWrite;
            kind = ImmSext5;
        end
        5'b11100: begin
            if (ins[1:0] == 2'b01 || ins[1:0] == 2'b11) begin
                r1 = rx;
                r2 = ry;
                srcB = SrcBReg;
                w = rz;
                alu = (ins[1:0] == 2'b01) ? AluAdd : AluSub;
            end
        end
        5'b11101: begin
            if (ins[4:0] == 5'b00000 && ins[7:5] == 3'b000) begin
                r1 = rx;  // JR
                br = 1'b1;
                cond = CondReg;
            end else if (ins[4:0] == 5'b01010) begin
                r1 = rx;
                r2 = ry;
                srcB = SrcBReg;
                alu = AluCmp;
                w = RegT;
            end else if (ins[4:0] == 5'b01100 || ins[4:0] == 5'b01101) begin
                r1 = rx;
                r2 = ry;
                srcB = SrcBReg;
                w = rx;
                alu = (ins[4:0] == 5'b01100) ? AluAnd : AluOr;
            end
        end
        default: ;
    endcase
    case (kind)
        ImmSext11: immVal = {{5{ins[10]}}, ins[10:0]};
        ImmSext8:  immVal = {{8{ins[7]}}, ins[7:0]};
        ImmZext8:  immVal = {8'h00, ins[7:0]};
        ImmSext5:  immVal = {{11{ins[4]}}, ins[4:0]};
        ImmSext4:  immVal = {{12{ins[3]}}, ins[3:0]};
        ImmShamt:  immVal = (ins[4:2] == 3'b000) ? 16'd8 : {13'd0, ins[4:2]};
        default:   immVal = 16'h0000;
    endcase
endfunction

`endif

/* dv/decodeStageTb.sv */
`default_nettype none

module decodeStageTb;
    timeunit 1ns;
    timeprecision 1ps;
    import decodePkg::*;

    `include "decodeRef.svh"

    localparam int CycleLimit = 6000;

    logic        clk;
    logic        rst;
    logic [15:0] instr;
    logic [3:0]  writeBackReg;
    logic [15:0] writeBackData;
    logic [3:0]  aluOp;
    logic [1:0]  srcBSel;
    logic [1:0]  memOp;
    logic        branch;
    logic [1:0]  branchCond;
    logic        wbFromMem;
    logic [15:0] imm;
    logic [3:0]  writeReg;
    logic [3:0]  readReg1;
    logic [3:0]  readReg2;
    logic [15:0] readData1;
    logic [15:0] readData2;

    logic [15:0] shadow [16];
    int          cycleCount;

    decodeStage #(.DataWidth(16)) UUT (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .aluOp         (aluOp),
        .srcBSel       (srcBSel),
        .memOp         (memOp),
        .branch        (branch),
        .branchCond    (branchCond),
        .wbFromMem     (wbFromMem),
        .imm           (imm),
        .writeReg      (writeReg),
        .readReg1      (readReg1),
        .readReg2      (readReg2),
        .readData1     (readData1),
        .readData2     (readData2)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [15:0] expectedRead(input logic [3:0] idx);
        if (idx == 4'd15) return 16'h0000;
        if (idx == writeBackReg) return writeBackData;  // Bypass
        return shadow[idx];
    endfunction

    always @(negedge clk) begin
        logic [3:0]  r1;
        logic [3:0]  r2;
        logic [3:0]  w;
        logic [3:0]  alu;
        logic [1:0]  srcB;
        logic [1:0]  mem;
        logic        br;
        logic [1:0]  cond;
        logic        wbm;
        logic [15:0] immVal;
        if (rst) begin
            decodeRef(instr, r1, r2, w, alu, srcB, mem, br, cond, wbm, immVal);
            checkValue("readReg1", {12'd0, r1}, {12'd0, readReg1});
            checkValue("readReg2", {12'd0, r2}, {12'd0, readReg2});
            checkValue("writeReg", {12'd0, w}, {12'd0, writeReg});
            checkValue("aluOp", {12'd0, alu}, {12'd0, aluOp});
            checkValue("srcBSel", {14'd0, srcB}, {14'd0, srcBSel});
            checkValue("memOp", {14'd0, mem}, {14'd0, memOp});
            checkValue("branch", {15'd0, br}, {15'd0, branch});
            checkValue("branchCond", {14'd0, cond}, {14'd0, branchCond});
            checkValue("wbFromMem", {15'd0, wbm}, {15'd0, wbFromMem});
            checkValue("imm", immVal, imm);
            checkValue("readData1", expectedRead(r1), readData1);
            checkValue("readData2", expectedRead(r2), readData2);
        end
    end

    // Shadow copy of the register file
    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 16; i++) begin
                shadow[i] <= 16'h0000;
            end
        end else if (writeBackReg != 4'd15) begin
            shadow[writeBackReg] <= writeBackData;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic driveCycle(input logic [15:0] ins, input logic [3:0] wbReg,
                              input logic [15:0] wbData);
        @(posedge clk);
        instr         <= ins;
        writeBackReg  <= wbReg;
        writeBackData <= wbData;
    endtask

    // Instruction that reads idx through readReg1
    function automatic logic [15:0] readerOf(input logic [3:0] idx);
        if (idx < 4'd8) return {5'b01111, 3'b000, idx[2:0], 5'd0};  // MOVE
        if (idx == 4'd8) return {5'b01100, 3'b011, 8'h00};          // ADDSP
        if (idx == 4'd9) return {5'b01100, 3'b000, 8'h00};          // BTEQZ
        return {5'b00001, 11'd0};
    endfunction

    // Three cycles of reset with a NOP and no write-back
    task automatic applyReset();
        rst           <= 1'b0;
        instr         <= 16'h0800;
        writeBackReg  <= 4'd15;
        writeBackData <= 16'h0000;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
    endtask

    // MOVE, ADDSP, BTEQZ and ADDU over every source index
    task automatic readAllSources();
        for (int i = 0; i < 16; i++) begin
            driveCycle(readerOf(4'(i)), 4'd15, 16'h0000);
        end
        for (int i = 0; i < 8; i++) begin
            driveCycle({5'b11100, 3'(i), 3'(7 - i), 3'b010, 2'b01}, 4'd15, 16'h0000);
        end
    endtask

    // Random word from one of the kept encodings
    function automatic logic [15:0] keptInstr();
        logic [15:0] word;
        int          kind;
        word = 16'($urandom);
        kind = $urandom_range(0, 22);
        case (kind)
            0:  word[15:11] = 5'b00001;
            1:  word[15:11] = 5'b00010;
            2:  word[15:11] = 5'b00100;
            3:  word[15:11] = 5'b00101;
            4: begin
                word[15:11] = 5'b00110;
                word[1:0]   = 2'b00;
            end
            5: begin
                word[15:11] = 5'b00110;
                word[1:0]   = 2'b11;
            end
            6:  word[15:11] = 5'b01000;
            7:  word[15:11] = 5'b01001;
            8: begin
                word[15:11] = 5'b01100;
                word[10:8]  = 3'b011;
            end
            9: begin
                word[15:11] = 5'b01100;
                word[10:8]  = 3'b000;
            end
            10: begin
                word[15:11] = 5'b01100;
                word[10:8]  = 3'b100;
            end
            11: word[15:11] = 5'b01101;
            12: word[15:11] = 5'b01111;
            13: word[15:11] = 5'b10010;
            14: word[15:11] = 5'b10011;
            15: word[15:11] = 5'b11010;
            16: word[15:11] = 5'b11011;
            17: begin
                word[15:11] = 5'b11100;
                word[1:0]   = 2'b01;
            end
            18: begin
                word[15:11] = 5'b11100;
                word[1:0]   = 2'b11;
            end
            19: begin  // JR
                word[15:11] = 5'b11101;
                word[7:0]   = 8'h00;
            end
            20: begin
                word[15:11] = 5'b11101;
                word[4:0]   = 5'b01010;
            end
            21: begin
                word[15:11] = 5'b11101;
                word[4:0]   = 5'b01100;
            end
            default: begin
                word[15:11] = 5'b11101;
                word[4:0]   = 5'b01101;
            end
        endcase
        return word;
    endfunction

    initial begin
        logic [3:0]  idx;
        logic [15:0] word;
        void'($urandom(32'h6bd1adda));
        cycleCount = 0;
        applyReset();

        // Every source index reads zero after reset
        readAllSources();

        // Random writes read back one cycle later
        for (int i = 0; i < 500; i++) begin
            idx = 4'($urandom);
            driveCycle(16'h0800, idx, 16'($urandom));
            driveCycle(readerOf(idx), 4'd15, 16'($urandom));
        end

        // Reset again over the written contents
        @(posedge clk);
        applyReset();
        readAllSources();

        // Bypass on both read ports
        for (int i = 0; i < 200; i++) begin
            word = {5'b11100, 3'($urandom), 3'($urandom), 3'($urandom), 2'b01};
            idx = (i % 2 == 0) ? {1'b0, word[10:8]} : {1'b0, word[7:5]};
            driveCycle(word, idx, 16'($urandom));
        end

        // Kept encodings with random write-back traffic
        for (int i = 0; i < 2000; i++) begin
            driveCycle(keptInstr(), 4'($urandom), 16'($urandom));
        end

        // Arbitrary words
        for (int i = 0; i < 500; i++) begin
            driveCycle(16'($urandom), 4'($urandom), 16'($urandom));
        end

        // Shift amounts including a zero field
        for (int i = 0; i < 200; i++) begin
            word = {5'b00110, 3'($urandom), 3'($urandom), 3'(i % 8),
                    (i % 3 == 0) ? 2'b11 : 2'b00};
            driveCycle(word, 4'd15, 16'h0000);
        end

        @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
logic/decodePkg.sv
logic/instrDecoder.sv
logic/immExtend.sv
logic/regFile.sv
logic/decodeStage.sv
dv/decodeStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module decodeStageTb -f src.f -o decodeStageSim &&
./obj_dir/decodeStageSim || exit 1
